/* Makefile */
SIM_TOOL  = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = mul_tb
FILE_LIST = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/mul_core_if.sv */
`timescale 1ns/1ns

interface mul_core_if import mul_pkg::*; ();

    operand_t a;        // multiplicand.
    operand_t b;        // multiplier, scanned one bit per calc cycle.
    logic     start;    // one-cycle command from the register block.
    logic     busy;
    product_t product;
    logic     done;     // held by the datapath until the next load.

    modport regs (
        output a,
        output b,
        output start,
        input  busy,
        input  product,
        input  done
    );

    modport ctrl (
        input  start,
        input  done,
        output busy
    );

    modport dp (
        input  a,
        input  b,
        output product,
        output done
    );

endinterface

/* hdl/mul_ctrl.sv */
`timescale 1ns/1ns

module mul_ctrl (
    input  logic clk,
    input  logic rst,
    mul_core_if.ctrl core,
    output logic load,
    output logic calc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (core.start) begin
                    state_next = ST_LOAD;
                end
            end
            ST_LOAD: begin
                state_next = ST_RUN;  // single clear cycle.
            end
            ST_RUN: begin
                if (core.done) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign load = (state == ST_LOAD);

    // stops the moment done shows, so exactly sixteen calc cycles run.
    assign calc = (state == ST_RUN) && !core.done;

    assign core.busy = load || calc;

    a_load_calc_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(load && calc)
    );

    // the datapath's done ends the run without a spare step.
    a_calc_falls_on_done: assert property (
        @(posedge clk) disable iff (rst)
        $rose(core.done) |-> $fell(calc)
    );

endmodule

/* hdl/mul_datapath.sv */
`timescale 1ns/1ns

module mul_datapath import mul_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic calc,
    mul_core_if.dp core
);

    index_t   bit_index;
    product_t acc;          // running sum of shifted rows.
    product_t pp;
    product_t pp_shifted;
    product_t acc_next;
    logic     last_step;

    assign last_step = (bit_index == LAST_INDEX);

    // one Baugh-Wooley row per cycle.
    always_comb begin
        pp = '0;
        if (core.b[bit_index[INDEX_W-2:0]]) begin
            pp[OPERAND_W-1:0] = core.a;
        end
        pp[OPERAND_W-1] = ~pp[OPERAND_W-1];  // the a15*bj term is negative.
        if (last_step) begin
            pp = ~pp;  // row b15 carries negative weight, upper ones give 2^31.
        end
        pp_shifted = pp << bit_index;
        acc_next   = acc + pp_shifted;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_index    <= '0;
            core.done    <= 1'b0;
            core.product <= '0;
        end else if (load) begin
            bit_index <= '0;
            core.done <= 1'b0;
        end else if (calc) begin
            bit_index <= bit_index + index_t'(1);
            if (last_step) begin
                core.product <= acc_next + CORRECTION;  // final row plus constant.
                core.done    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc <= '0;
        end else if (calc) begin
            acc <= acc_next;
        end
    end

    // the controller must stop calc before the index runs past the last row.
    a_index_in_range: assert property (
        @(posedge clk) disable iff (rst)
        calc |-> (bit_index <= LAST_INDEX)
    );

endmodule

/* hdl/mul_pkg.sv */
package mul_pkg;

    localparam int OPERAND_W = 16;  // each signed operand.
    localparam int PRODUCT_W = 32;
    localparam int INDEX_W   = 5;   // counts one past the last row.
    localparam int ADDR_W    = 4;   // decoded part of the AXI address.
    localparam int DATA_W    = 32;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [1:0]           resp_t;

    // register map, one word each.
    localparam addr_t REG_CTRL     = 4'h0;
    localparam addr_t REG_STATUS   = 4'h4;
    localparam addr_t REG_OPERANDS = 4'h8;  // a in the low half, b in the high half.
    localparam addr_t REG_PRODUCT  = 4'hC;

    // bit positions inside the control and status words.
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // last row of the shift-and-add, the one that gets fully inverted.
    localparam index_t LAST_INDEX = index_t'(OPERAND_W - 1);

    // only the 2^16 term, the 2^31 term comes in with the inverted last row.
    localparam product_t CORRECTION = 32'h0001_0000;

endpackage

/* hdl/mul_regs.sv */
`timescale 1ns/1ns

module mul_regs import mul_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  data_t wdata,
    input  logic  wvalid,
    output logic  wready,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output data_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready,
    mul_core_if.regs core
);

    logic  wr_accept;
    logic  rd_accept;
    logic  run_busy;
    logic  done_flag;
    logic  start_req;
    logic  opnd_we;
    resp_t wr_resp;
    resp_t rd_resp;
    data_t rd_data;
    data_t status_word;

    // address and data are taken together, one write in flight.
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    // the start pulse itself counts as busy, it precedes the load cycle.
    assign run_busy = core.busy || core.start;

    // sticky: the datapath keeps done until a new start reaches load.
    assign done_flag = core.done && !run_busy;

    always_comb begin
        status_word = '0;
        status_word[STATUS_BUSY_BIT] = run_busy;
        status_word[STATUS_DONE_BIT] = done_flag;
    end

    // write decode.
    always_comb begin
        wr_resp   = RESP_OKAY;
        start_req = 1'b0;
        opnd_we   = 1'b0;
        case (awaddr)
            REG_CTRL: begin
                start_req = wdata[CTRL_START_BIT] && !run_busy;  // dropped quietly when busy.
            end
            REG_OPERANDS: begin
                if (run_busy) begin
                    wr_resp = RESP_SLVERR;
                end else begin
                    opnd_we = 1'b1;
                end
            end
            default: begin
                wr_resp = RESP_SLVERR;  // status, product and holes.
            end
        endcase
    end

    // read decode.
    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_CTRL: begin
                rd_data = '0;  // start is write-1-to-act.
            end
            REG_STATUS: begin
                rd_data = status_word;
            end
            REG_OPERANDS: begin
                rd_data = {core.b, core.a};
            end
            REG_PRODUCT: begin
                rd_data = core.product;
            end
            default: begin
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid     <= 1'b0;
            bresp      <= RESP_OKAY;
            core.start <= 1'b0;
        end else begin
            core.start <= wr_accept && start_req;  // lines up with bvalid.
            if (wr_accept) begin
                bvalid <= 1'b1;
                bresp  <= wr_resp;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
        end else begin
            if (rd_accept) begin
                rvalid <= 1'b1;
                rresp  <= rd_resp;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept && opnd_we) begin
            core.a <= wdata[OPERAND_W-1:0];
            core.b <= wdata[DATA_W-1:OPERAND_W];
        end
    end

    // a new run only begins once the controller is back in idle.
    a_start_not_busy: assert property (
        @(posedge clk) disable iff (rst)
        $rose(core.start) |-> !core.busy
    );

endmodule

/* hdl/mul_top.sv */
`timescale 1ns/1ns

module mul_top import mul_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  data_t wdata,
    input  logic  wvalid,
    output logic  wready,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output data_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready
);

    logic load;
    logic calc;

    mul_core_if core ();

    mul_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .core    (core.regs)
    );

    mul_ctrl u_ctrl (
        .clk  (clk),
        .rst  (rst),
        .core (core.ctrl),
        .load (load),
        .calc (calc)
    );

    mul_datapath u_datapath (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .calc (calc),
        .core (core.dp)
    );

endmodule

/* list.f */
hdl/mul_pkg.sv
hdl/mul_core_if.sv
hdl/mul_regs.sv
hdl/mul_ctrl.sv
hdl/mul_datapath.sv
hdl/mul_top.sv
testbench/mul_tb.sv

/* testbench/mul_patterns.txt */
# columns: a b expected_product, all in hex
# a and b are signed 16-bit, the product is signed 32-bit
0000 0000 00000000
0001 0001 00000001
ffff 0001 ffffffff
ffff ffff 00000001
8000 8000 40000000
7fff 8000 c0008000
7fff 7fff 3fff0001
0003 fffb fffffff1
fff9 0006 ffffffd6
1234 0010 00012340
8000 0001 ffff8000
8000 ffff 00008000
0000 8000 00000000
00ff ff00 ffff0100
0064 ff9c ffffd8f0
ff9c ff9c 00002710

/* testbench/mul_tb.sv */
`timescale 1ns/1ns

module mul_tb import mul_pkg::*; ();

    localparam int    HANDSHAKE_LIMIT = 50;   // cycles allowed per channel wait.
    localparam int    POLL_LIMIT      = 40;   // status reads before giving up.
    localparam int    RANDOM_CASES    = 20;
    localparam addr_t UNMAPPED_ADDR   = 4'h6;
    localparam data_t ST_BUSY_ONLY    = 32'h1;
    localparam data_t ST_DONE_ONLY    = 32'h2;

    logic  clk;
    logic  rst;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;

    int          error_count;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] lcg_state;

    mul_top u_mul_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // reference result, plain two's complement arithmetic.
    function automatic data_t signed_product(input operand_t a, input operand_t b);
        shortint sa;
        shortint sb;
        sa = shortint'(a);
        sb = shortint'(b);
        return data_t'(int'(sa) * int'(sb));
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // bready stays low for stall cycles while the response is watched.
    task automatic axi_write(input addr_t addr, input data_t data, input int stall,
                             output resp_t resp);
        int waited;
        @(posedge clk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!(awready && wready) && waited < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(awready && wready)) abort_run("write address and data were never accepted");
        @(posedge clk);  // taken on this edge.
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        @(negedge clk);
        while (!bvalid && waited < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!bvalid) abort_run("no write response arrived");
        resp = bresp;
        repeat (stall) begin
            @(negedge clk);
            check_value("bvalid", data_t'(1'b1), data_t'(bvalid));
            check_value("bresp", data_t'(resp), data_t'(bresp));
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, input int stall, output data_t data,
                            output resp_t resp);
        int waited;
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!arready && waited < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!arready) abort_run("read address was never accepted");
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        waited  = 0;
        @(negedge clk);
        while (!rvalid && waited < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rvalid) abort_run("no read response arrived");
        data = rdata;
        resp = rresp;
        repeat (stall) begin
            @(negedge clk);
            check_value("rvalid", data_t'(1'b1), data_t'(rvalid));
            check_value("rdata", data, rdata);
            check_value("rresp", data_t'(resp), data_t'(rresp));
        end
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic poll_done(output data_t status);
        resp_t resp;
        int    polls;
        polls  = 0;
        status = '0;
        while (!status[STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
            axi_read(REG_STATUS, 0, status, resp);
            polls++;
        end
        if (!status[STATUS_DONE_BIT]) abort_run("done never showed up in STATUS");
    endtask

    task automatic multiply(input operand_t a, input operand_t b, input int stall,
                            output data_t product);
        resp_t resp;
        data_t status;
        axi_write(REG_OPERANDS, {b, a}, stall, resp);
        check_value("bresp", data_t'(RESP_OKAY), data_t'(resp));
        axi_write(REG_CTRL, 32'h1, stall, resp);
        check_value("bresp", data_t'(RESP_OKAY), data_t'(resp));
        poll_done(status);
        check_value("status", ST_DONE_ONLY, status);  // done set, busy clear.
        axi_read(REG_PRODUCT, stall, product, resp);
        check_value("rresp", data_t'(RESP_OKAY), data_t'(resp));
    endtask

    initial begin
        int       errs;
        int       fd;
        int       count;
        string    line;
        operand_t pa;
        operand_t pb;
        data_t    pexp;
        data_t    got;
        resp_t    resp;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        lcg_state = 32'h3bb5;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = error_count;
        axi_read(REG_STATUS, 0, got, resp);
        check_value("status", 32'h0, got);
        check_value("rresp", data_t'(RESP_OKAY), data_t'(resp));
        axi_read(REG_PRODUCT, 0, got, resp);
        check_value("product", 32'h0, got);
        check_value("rresp", data_t'(RESP_OKAY), data_t'(resp));
        end_test("reset_values", errs);

        errs  = error_count;
        count = 0;
        fd = $fopen("testbench/mul_patterns.txt", "r");
        if (fd == 0) abort_run("cannot open testbench/mul_patterns.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h", pa, pb, pexp) == 3) begin
                    multiply(pa, pb, 0, got);
                    check_value("product", pexp, got);
                    count++;
                end
            end
        end
        $fclose(fd);
        if (count == 0) begin
            $display("no operand pairs were read from the pattern file");
            error_count++;
        end
        end_test("directed_patterns", errs);

        errs = error_count;
        for (int i = 0; i < RANDOM_CASES; i++) begin
            lcg_state = lcg_next(lcg_state);
            pa = lcg_state[31:16];  // upper bits of an LCG are the better mixed.
            lcg_state = lcg_next(lcg_state);
            pb = lcg_state[31:16];
            multiply(pa, pb, 0, got);
            check_value("product", signed_product(pa, pb), got);
        end
        end_test("random_operands", errs);

        // the writes below land well inside the 18 cycle run.
        errs = error_count;
        axi_write(REG_OPERANDS, 32'h0056_1234, 0, resp);
        axi_write(REG_CTRL, 32'h1, 0, resp);
        axi_read(REG_STATUS, 0, got, resp);
        check_value("status", ST_BUSY_ONLY, got);
        axi_write(REG_OPERANDS, 32'h7fff_7fff, 0, resp);
        check_value("bresp", data_t'(RESP_SLVERR), data_t'(resp));
        axi_write(REG_CTRL, 32'h1, 0, resp);
        check_value("bresp", data_t'(RESP_OKAY), data_t'(resp));
        repeat (6) @(posedge clk);
        axi_read(REG_STATUS, 0, got, resp);  // first run is over, a restarted one would be busy.
        check_value("status", ST_DONE_ONLY, got);
        poll_done(got);
        check_value("status", ST_DONE_ONLY, got);
        axi_read(REG_PRODUCT, 0, got, resp);
        check_value("product", signed_product(16'h1234, 16'h0056), got);
        axi_read(REG_OPERANDS, 0, got, resp);
        check_value("operands", 32'h0056_1234, got);
        end_test("busy_protection", errs);

        errs = error_count;
        axi_write(REG_PRODUCT, 32'hdead_beef, 0, resp);
        check_value("bresp", data_t'(RESP_SLVERR), data_t'(resp));
        axi_read(REG_PRODUCT, 0, got, resp);
        check_value("product", signed_product(16'h1234, 16'h0056), got);
        check_value("rresp", data_t'(RESP_OKAY), data_t'(resp));
        axi_write(UNMAPPED_ADDR, 32'h1, 0, resp);
        check_value("bresp", data_t'(RESP_SLVERR), data_t'(resp));
        axi_read(UNMAPPED_ADDR, 0, got, resp);
        check_value("rdata", 32'h0, got);
        check_value("rresp", data_t'(RESP_SLVERR), data_t'(resp));
        end_test("unmapped_and_read_only", errs);

        errs = error_count;
        multiply(16'h8001, 16'h7ffe, 6, got);
        check_value("product", signed_product(16'h8001, 16'h7ffe), got);
        axi_read(REG_PRODUCT, 8, got, resp);
        check_value("product", signed_product(16'h8001, 16'h7ffe), got);
        end_test("back_pressure", errs);

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
